//--- Bender.yml
package:
  name: mdio_slave

sources:
  - common/mdio_pkg.sv
  - mdio_frontend/mdio_frontend.sv
  - logic/mdio_backend.sv
  - logic/mdio_reg_file.sv
  - logic/mdio_slave_top.sv
  - target: simulation
    files:
      - sim/mdio_checker.sv
      - sim/tb_mdio_slave.sv

//--- common/mdio_pkg.sv
// -------------------------------------------------------------------------
// shared definitions for the mdio slave
// frame union with clause 22 / clause 45 views, strap config struct,
// start codes, opcodes, frontend state codes and mmd constants
// -------------------------------------------------------------------------
`default_nettype none

package mdio_pkg;

    // clause 22 view of a captured frame, msb is the first bit on the wire
    typedef struct packed {
        logic [1:0]  start;
        logic [1:0]  op;
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [1:0]  turnaround;
        logic [15:0] data;
    } mdio_c22_t;

    typedef struct packed {
        logic [1:0]  start;
        logic [1:0]  op;
        logic [4:0]  port_addr;
        logic [4:0]  dev_addr;
        logic [1:0]  turnaround;
        logic [15:0] data;        // register address or register value
    } mdio_c45_t;

    typedef union packed {
        mdio_c22_t c22;
        mdio_c45_t c45;
    } mdio_frame_u;

    // static straps and configuration
    typedef struct packed {
        logic [4:0] legal_phy_addr;
        logic [4:0] legal_phy_addr_mask;
        logic [4:0] broadcast_addr;
        logic       broadcast_mode;
        logic       non_zero_detect;
        logic       opendrain_mode;
        logic       enable;
    } mdio_cfg_t;

    localparam logic [1:0] START_C22 = 2'b01;
    localparam logic [1:0] START_C45 = 2'b00;

    localparam logic [1:0] OP_C22_WRITE    = 2'b01;
    localparam logic [1:0] OP_C22_READ     = 2'b10;
    localparam logic [1:0] OP_C45_ADDR     = 2'b00;
    localparam logic [1:0] OP_C45_WRITE    = 2'b01;
    localparam logic [1:0] OP_C45_READ_INC = 2'b10;
    localparam logic [1:0] OP_C45_READ     = 2'b11;

    // frontend fsm
    localparam logic [1:0] FE_IDLE = 2'd0;
    localparam logic [1:0] FE_ST   = 2'd1;
    localparam logic [1:0] FE_RX   = 2'd2;
    localparam logic [1:0] FE_TX   = 2'd3;

    localparam logic [4:0]  MMD_DEVAD     = 5'd1;        // only supported mmd
    localparam logic [15:0] UNMAPPED_DATA = 16'hffff;

endpackage

`default_nettype wire

//--- flist.f
common/mdio_pkg.sv
mdio_frontend/mdio_frontend.sv
logic/mdio_backend.sv
logic/mdio_reg_file.sv
logic/mdio_slave_top.sv
sim/mdio_checker.sv
sim/tb_mdio_slave.sv

//--- logic/mdio_backend.sv
// -------------------------------------------------------------------------
// mdio backend
// clause 22 / clause 45 frame decode, clause 45 address register,
// read response and register file write strobes
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdio_backend
(
    input  logic                   clk_25m,
    input  logic                   rst_n,
    input  logic                   enable,
    input  mdio_pkg::mdio_frame_u  rx_frame,
    input  logic                   info_done,
    input  logic                   data_done,
    input  logic [15:0]            rd_data,
    output logic [15:0]            resp_rdata,
    output logic                   resp_ready,
    output logic                   wr_en,
    output logic [4:0]             addr,
    output logic [15:0]            wr_data
);

    logic        is_c22;
    logic        dev_ok;
    logic        wr_req;
    logic [15:0] c45_addr;
    logic [4:0]  rd_addr;
    logic [4:0]  wr_addr;
    logic [4:0]  clr_ptr;
    logic        clr_pend;

    assign is_c22 = rx_frame.c22.start == mdio_pkg::START_C22;
    assign dev_ok = (rx_frame.c45.start == mdio_pkg::START_C45) &&
                    (rx_frame.c45.dev_addr == mdio_pkg::MMD_DEVAD);

    assign rd_addr = is_c22 ? rx_frame.c22.reg_addr : c45_addr[4:0];  // above 31 wraps
    assign addr    = wr_en ? wr_addr : rd_addr;

    assign wr_req = data_done &&
                    ((is_c22 && rx_frame.c22.op == mdio_pkg::OP_C22_WRITE) ||
                     (dev_ok && rx_frame.c45.op == mdio_pkg::OP_C45_WRITE));

    // ---------------------------------------------------------------------
    // read response, frontend already decided this frame is a read
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            resp_ready <= 1'b0;
        else if (!enable)
            resp_ready <= 1'b0;
        else
            resp_ready <= info_done && rx_frame.c22.op[1];
    end

    always_ff @(posedge clk_25m)
    begin
        if (info_done)
            resp_rdata <= (is_c22 || dev_ok) ? rd_data : mdio_pkg::UNMAPPED_DATA;
    end

    // clause 45 address register of the one mmd
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            c45_addr <= 16'd0;
        else if (!enable)
            c45_addr <= 16'd0;
        else if (data_done && dev_ok)
        begin
            if (rx_frame.c45.op == mdio_pkg::OP_C45_ADDR)
                c45_addr <= rx_frame.c45.data;
            else if (rx_frame.c45.op == mdio_pkg::OP_C45_READ_INC)
                c45_addr <= c45_addr + 16'd1;      // after the read is done
        end
    end

    // ---------------------------------------------------------------------
    // write strobe, plus a zero sweep of all registers after enable returns
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_en    <= 1'b0;
            clr_pend <= 1'b0;
            clr_ptr  <= 5'd0;
        end
        else if (!enable)
        begin
            wr_en    <= 1'b0;
            clr_pend <= 1'b1;
            clr_ptr  <= 5'd0;
        end
        else if (clr_pend)
        begin
            wr_en    <= 1'b1;
            clr_ptr  <= clr_ptr + 5'd1;
            clr_pend <= clr_ptr != 5'd31;
        end
        else
            wr_en <= wr_req;
    end

    always_ff @(posedge clk_25m)
    begin
        if (clr_pend)
        begin
            wr_addr <= clr_ptr;
            wr_data <= 16'd0;
        end
        else if (wr_req)
        begin
            wr_addr <= rd_addr;
            wr_data <= rx_frame.c22.data;
        end
    end

endmodule

`default_nettype wire

//--- logic/mdio_reg_file.sv
// -------------------------------------------------------------------------
// 32 x 16 register array, synchronous write, combinational read
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdio_reg_file
(
    input  logic        clk_25m,
    input  logic        rst_n,
    input  logic        wr_en,
    input  logic [4:0]  addr,
    input  logic [15:0] wr_data,
    output logic [15:0] rd_data
);

    logic [15:0] regs [32];

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 16'd0;      // all registers read 0 after reset
        end
        else if (wr_en)
            regs[addr] <= wr_data;
    end

    assign rd_data = regs[addr];

endmodule

`default_nettype wire

//--- logic/mdio_slave_top.sv
// -------------------------------------------------------------------------
// mdio slave top level
// frontend, backend and register file
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdio_slave_top
(
    input  logic                 clk_25m,
    input  logic                 rst_n,
    input  logic                 mdc,
    input  logic                 mdio_in,
    input  mdio_pkg::mdio_cfg_t  cfg,
    output logic                 mdio_out,
    output logic                 mdio_oe
);

    mdio_pkg::mdio_frame_u rx_frame;
    logic                  info_done;
    logic                  data_done;
    logic [15:0]           resp_rdata;
    logic                  resp_ready;
    logic                  wr_en;
    logic [4:0]            addr;
    logic [15:0]           wr_data;
    logic [15:0]           rd_data;

    mdio_frontend u_frontend
    (
        .clk_25m    (clk_25m),
        .rst_n      (rst_n),
        .mdc        (mdc),
        .mdio_in    (mdio_in),
        .cfg        (cfg),
        .resp_rdata (resp_rdata),
        .resp_ready (resp_ready),
        .mdio_out   (mdio_out),
        .mdio_oe    (mdio_oe),
        .rx_frame   (rx_frame),
        .info_done  (info_done),
        .data_done  (data_done)
    );

    mdio_backend u_backend
    (
        .clk_25m    (clk_25m),
        .rst_n      (rst_n),
        .enable     (cfg.enable),
        .rx_frame   (rx_frame),
        .info_done  (info_done),
        .data_done  (data_done),
        .rd_data    (rd_data),
        .resp_rdata (resp_rdata),
        .resp_ready (resp_ready),
        .wr_en      (wr_en),
        .addr       (addr),
        .wr_data    (wr_data)
    );

    mdio_reg_file u_reg_file
    (
        .clk_25m (clk_25m),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- mdio_frontend/mdio_frontend.sv
// -------------------------------------------------------------------------
// mdio frontend in the clk_25m domain
// pin synchronisers and glitch filter, frame fsm, phy address check
// and serial read-data driver
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdio_frontend
(
    input  logic                   clk_25m,
    input  logic                   rst_n,
    input  logic                   mdc,           // at most 2.5 MHz
    input  logic                   mdio_in,
    input  mdio_pkg::mdio_cfg_t    cfg,
    input  logic [15:0]            resp_rdata,
    input  logic                   resp_ready,
    output logic                   mdio_out,
    output logic                   mdio_oe,
    output mdio_pkg::mdio_frame_u  rx_frame,
    output logic                   info_done,
    output logic                   data_done
);

    // bit 1 is mdc, bit 0 is mdio
    logic [1:0] pin_s0;
    logic [1:0] pin_s1;
    logic [1:0] pin_s2;
    logic [1:0] pin_filt;
    logic [1:0] flt_take;
    logic       mdc_filt_r;
    logic       mdc_pos;
    logic       mdc_neg;
    logic       mdc_pos_pre;
    logic       mdio_filt;
    logic       mdio_neg_flag;

    logic [1:0] state;
    logic [1:0] next_state;
    logic [4:0] count;

    logic       phyaddr_done;
    logic       phyaddr_done_r;
    logic [4:0] phy_addr;
    logic [4:0] true_addr;
    logic       latch_done;
    logic       legal;

    logic [15:0] tx_data;
    logic        shift_en;
    logic        oe_tmp;
    logic        out_tmp;

    // ---------------------------------------------------------------------
    // synchroniser and one-sample glitch filter
    // ---------------------------------------------------------------------
    assign flt_take = (pin_s1 ^ pin_s2) & (pin_s2 ^ pin_filt);

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pin_s0     <= 2'b11;
            pin_s1     <= 2'b11;
            pin_s2     <= 2'b11;
            pin_filt   <= 2'b11;
            mdc_filt_r <= 1'b1;
        end
        else
        begin
            pin_s0     <= {mdc, mdio_in};
            pin_s1     <= pin_s0;
            pin_s2     <= pin_s1;
            pin_filt   <= (flt_take & pin_s1) | (~flt_take & pin_s2);
            mdc_filt_r <= pin_filt[1];
        end
    end

    assign mdio_filt   = pin_filt[0];
    assign mdc_pos     = ~mdc_filt_r & pin_filt[1];
    assign mdc_neg     = mdc_filt_r & ~pin_filt[1];
    assign mdc_pos_pre = pin_s2[1] & pin_s1[1] & ~pin_filt[1];   // one cycle before mdc_pos

    // a start needs a real falling edge, so a line stuck low stays idle
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            mdio_neg_flag <= 1'b0;
        else if (!cfg.enable || state != mdio_pkg::FE_IDLE)
            mdio_neg_flag <= 1'b0;
        else if (pin_s2[0] & pin_s1[0] & ~mdio_filt)
            mdio_neg_flag <= 1'b0;
        else if (~pin_s2[0] & ~pin_s1[0] & mdio_filt)
            mdio_neg_flag <= 1'b1;
    end

    // ---------------------------------------------------------------------
    // frame fsm and capture
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            state <= mdio_pkg::FE_IDLE;
        else if (!cfg.enable)
            state <= mdio_pkg::FE_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            mdio_pkg::FE_IDLE:
                if (mdio_neg_flag && mdc_pos_pre)
                    next_state = mdio_pkg::FE_ST;
            mdio_pkg::FE_ST:
                if (count == 5'd9 && mdc_neg)
                    next_state = mdio_pkg::FE_RX;
            mdio_pkg::FE_RX, mdio_pkg::FE_TX:
                // op[1] set means a read in both clauses
                if (state == mdio_pkg::FE_RX && count == 5'd14 &&
                    rx_frame.c22.op[1] && legal)
                    next_state = mdio_pkg::FE_TX;
                else if (count == 5'd0 && mdc_pos)
                    next_state = mdio_filt ? mdio_pkg::FE_IDLE : mdio_pkg::FE_ST;
            default:
                next_state = mdio_pkg::FE_IDLE;
        endcase
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            count <= 5'd0;
        else if (!cfg.enable || state == mdio_pkg::FE_IDLE)
            count <= 5'd0;
        else if (mdc_neg)
            count <= count + 5'd1;     // wraps after bit 31
    end

    // idle pattern already holds the 0 of the first start bit
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            rx_frame <= 32'h7fff_ffff;
        else if (!cfg.enable || state == mdio_pkg::FE_IDLE)
            rx_frame <= 32'h7fff_ffff;
        else if (mdc_pos)
            rx_frame[5'd31 - count] <= mdio_filt;
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phyaddr_done   <= 1'b0;
            phyaddr_done_r <= 1'b0;
            info_done      <= 1'b0;
            data_done      <= 1'b0;
        end
        else
        begin
            phyaddr_done   <= (count == 5'd8) && mdc_pos;
            phyaddr_done_r <= phyaddr_done;
            info_done      <= legal && (count == 5'd13) && mdc_pos;
            data_done      <= legal && (count == 5'd31) && mdc_pos;
        end
    end

    // ---------------------------------------------------------------------
    // phy address check
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            phy_addr <= 5'd0;
        else if (!cfg.enable)
            phy_addr <= 5'd0;
        else if (phyaddr_done)
            phy_addr <= rx_frame.c22.phy_addr;
    end

    // zero strap with non_zero_detect takes the first address seen
    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            true_addr  <= 5'd0;
            latch_done <= 1'b0;
        end
        else if (cfg.non_zero_detect && cfg.legal_phy_addr == 5'd0)
        begin
            if (phyaddr_done_r && !latch_done)
            begin
                true_addr  <= phy_addr;
                latch_done <= 1'b1;
            end
        end
        else
            true_addr <= cfg.legal_phy_addr;
    end

    assign legal = ((phy_addr & cfg.legal_phy_addr_mask) ==
                    (true_addr & cfg.legal_phy_addr_mask)) ||
                   (cfg.broadcast_mode && phy_addr == cfg.broadcast_addr);

    // ---------------------------------------------------------------------
    // read data driver
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_25m)
    begin
        if (resp_ready)
            tx_data <= resp_rdata;
        else if (shift_en && mdc_pos)
            tx_data <= {tx_data[14:0], 1'b0};
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_en <= 1'b0;
            oe_tmp   <= 1'b0;
            out_tmp  <= 1'b0;
        end
        else if (state != mdio_pkg::FE_TX)
        begin
            shift_en <= 1'b0;
            oe_tmp   <= 1'b0;
            out_tmp  <= 1'b0;
        end
        else
        begin
            if (count == 5'd15 && mdc_pos_pre)
                shift_en <= 1'b1;
            else if (count == 5'd30 && mdc_pos_pre)
                shift_en <= 1'b0;
            if (count == 5'd14 && mdc_pos)
                oe_tmp <= 1'b1;        // second turnaround bit
            else if (count == 5'd31 && mdc_pos_pre)
                oe_tmp <= 1'b0;
            if (mdc_pos)
                out_tmp <= (count == 5'd14) ? 1'b0 : tx_data[15];
        end
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mdio_oe  <= 1'b0;
            mdio_out <= 1'b0;
        end
        else if (!cfg.enable)
        begin
            mdio_oe  <= 1'b0;
            mdio_out <= 1'b0;
        end
        else
        begin
            mdio_out <= out_tmp;
            mdio_oe  <= cfg.opendrain_mode ? (oe_tmp & ~out_tmp) : oe_tmp;
        end
    end

endmodule

`default_nettype wire

//--- sim/mdio_checker.sv
// --------------------------------------------------------------------------
// mdio checker, reference register model of the slave,
// read-data capture from the bus, comparison and per-test result lines
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdio_checker
(
    input  logic                 clk_25m,
    input  logic                 mdc,
    input  logic                 mdio_line,
    input  logic                 mdio_out,
    input  logic                 mdio_oe,
    input  mdio_pkg::mdio_cfg_t  cfg,
    input  int                   frame_seq,     // bumps at the start of every logged frame
    input  logic [31:0]          frame_word,
    input  int                   test_seq,
    output int                   check_count,
    output int                   error_count
);

    logic [15:0] ref_regs [32];
    logic [15:0] ref_c45_addr;
    logic        latched = 1'b0;
    logic [4:0]  latched_addr;
    logic        en_d = 1'b1;
    logic        is_read;
    logic        tad_ok;
    logic        stray;
    logic [15:0] got;
    logic [15:0] exp_val;
    int          errs_at_test = 0;
    mdio_pkg::mdio_frame_u fr;

    initial
    begin
        check_count  = 0;
        error_count  = 0;
        ref_c45_addr = 16'd0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = 16'd0;
    end

    // address match under the strap, mask and broadcast rules
    function automatic logic addr_legal(input logic [4:0] phy);
        logic [4:0] strap;
        strap = (cfg.non_zero_detect && cfg.legal_phy_addr == 5'd0) ?
                latched_addr : cfg.legal_phy_addr;
        return ((phy & cfg.legal_phy_addr_mask) == (strap & cfg.legal_phy_addr_mask)) ||
               (cfg.broadcast_mode && phy == cfg.broadcast_addr);
    endfunction

    // expected read value from the model state
    function automatic logic [15:0] ref_read(input mdio_pkg::mdio_frame_u f);
        if (f.c22.start == mdio_pkg::START_C22)
            return ref_regs[f.c22.reg_addr];
        if (f.c45.dev_addr != mdio_pkg::MMD_DEVAD)
            return mdio_pkg::UNMAPPED_DATA;
        return ref_regs[ref_c45_addr[4:0]];        // addresses wrap in 5 bits
    endfunction

    task automatic ref_update(input mdio_pkg::mdio_frame_u f);
        if (f.c22.start == mdio_pkg::START_C22)
        begin
            if (f.c22.op == mdio_pkg::OP_C22_WRITE)
                ref_regs[f.c22.reg_addr] = f.c22.data;
        end
        else if (f.c45.dev_addr == mdio_pkg::MMD_DEVAD)
        begin
            case (f.c45.op)
                mdio_pkg::OP_C45_ADDR:     ref_c45_addr = f.c45.data;
                mdio_pkg::OP_C45_WRITE:    ref_regs[ref_c45_addr[4:0]] = f.c45.data;
                mdio_pkg::OP_C45_READ_INC: ref_c45_addr = ref_c45_addr + 16'd1;
                default: ;
            endcase
        end
    endtask

    // --------------------------------------------------------------------------
    // per-frame capture and compare
    // --------------------------------------------------------------------------
    always @(frame_seq)
    begin
        fr = frame_word;
        if (cfg.non_zero_detect && cfg.legal_phy_addr == 5'd0 && !latched)
        begin
            latched      = 1'b1;       // first address seen becomes the strap
            latched_addr = fr.c22.phy_addr;
        end
        is_read = addr_legal(fr.c22.phy_addr) && fr.c22.op[1];
        tad_ok  = 1'b1;
        stray   = 1'b0;
        got     = 16'd0;
        for (int i = 0; i < 32; i++)
        begin
            @(posedge mdc);
            if (is_read && i == 15 && !(mdio_oe && !mdio_out))
                tad_ok = 1'b0;
            if (is_read && i >= 16)
                got = {got[14:0], mdio_line};
            if (!is_read && mdio_oe)
                stray = 1'b1;
        end
        check_count++;
        if (is_read)
        begin
            exp_val = ref_read(fr);
            if (!tad_ok)
            begin
                $display("at %0t the DUT did not drive the read turnaround low", $time);
                error_count++;
            end
            if (got !== exp_val)
            begin
                $display("Fail at %0t: mdio_line read data expected %h actual %h",
                         $time, exp_val, got);
                error_count++;
            end
        end
        else if (stray)
        begin
            $display("at %0t the DUT drove mdio during a frame it should ignore", $time);
            error_count++;
        end
        if (addr_legal(fr.c22.phy_addr))
            ref_update(fr);
    end

    // open-drain and enable rules, checked every cycle
    always @(negedge clk_25m)
    begin
        if (cfg.opendrain_mode && mdio_oe && mdio_out)
        begin
            $display("at %0t the DUT drove a one in open-drain mode", $time);
            error_count++;
        end
        if (!cfg.enable && !en_d && mdio_oe)
        begin
            $display("at %0t mdio_oe is still high while enable is low", $time);
            error_count++;
        end
        if (!cfg.enable)
        begin
            ref_c45_addr = 16'd0;
            for (int i = 0; i < 32; i++)
                ref_regs[i] = 16'd0;
        end
        en_d = cfg.enable;
    end

    always @(test_seq)
    begin
        $display("test %0d done: %0d errors in this test", test_seq,
                 error_count - errs_at_test);
        errs_at_test = error_count;
    end

endmodule

`default_nettype wire

//--- sim/tb_mdio_slave.sv
// --------------------------------------------------------------------------
// mdio slave testbench, clock, reset, mdio master frame tasks,
// test sequence, watchdog and final report
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mdio_slave;

    localparam int N_FRAMES = 64;                       // upper bound on frames sent

    logic                clk_25m = 1'b0;
    logic                rst_n   = 1'b0;
    logic                mdc     = 1'b1;
    logic                master_line = 1'b1;
    mdio_pkg::mdio_cfg_t cfg = '{5'd3, 5'h1f, 5'h1f, 1'b0, 1'b0, 1'b0, 1'b1};
    logic                mdio_out;
    logic                mdio_oe;
    wire                 mdio_line = mdio_oe ? mdio_out : master_line;   // pulled up bus
    int                  frame_seq = 0;
    logic [31:0]         frame_word = 32'd0;
    int                  test_seq = 0;
    int                  check_count;
    int                  error_count;
    integer              seed = 32'h0c536f04;
    logic [15:0]         d0;
    logic [15:0]         d1;
    logic [31:0]         partial_word;

    mdio_slave_top DUT
    (
        .clk_25m  (clk_25m),
        .rst_n    (rst_n),
        .mdc      (mdc),
        .mdio_in  (mdio_line),
        .cfg      (cfg),
        .mdio_out (mdio_out),
        .mdio_oe  (mdio_oe)
    );

    mdio_checker u_checker
    (
        .clk_25m (clk_25m), .mdc (mdc), .mdio_line (mdio_line),
        .mdio_out (mdio_out), .mdio_oe (mdio_oe), .cfg (cfg),
        .frame_seq (frame_seq), .frame_word (frame_word), .test_seq (test_seq),
        .check_count (check_count), .error_count (error_count)
    );

    initial
    begin
        forever
            #20 clk_25m = ~clk_25m;        // 40 ns period
    end

    // one mdio bit, 16 clocks, master changes data while mdc is low
    task automatic drive_bit(input logic b);
        @(posedge clk_25m);
        mdc         <= 1'b0;
        master_line <= b;
        repeat (8) @(posedge clk_25m);
        mdc <= 1'b1;
        repeat (7) @(posedge clk_25m);
    endtask

    task automatic send_frame(input logic [31:0] word, input logic preamble);
        if (preamble)
            repeat (32) drive_bit(1'b1);
        @(posedge clk_25m);
        frame_word <= word;
        frame_seq  <= frame_seq + 1;
        for (int i = 0; i < 32; i++)
            drive_bit((word[29:28] == 2'b10 || word[29:28] == 2'b11) && i >= 14 ?
                      1'b1 : word[31 - i]);        // released after a read header
    endtask

    function automatic logic [31:0] c22(input logic [1:0] op, input logic [4:0] phy,
                                        input logic [4:0] r, input logic [15:0] d);
        return {mdio_pkg::START_C22, op, phy, r, 2'b10, d};
    endfunction

    function automatic logic [31:0] c45(input logic [1:0] op, input logic [4:0] dev,
                                        input logic [15:0] d);
        return {mdio_pkg::START_C45, op, 5'd3, dev, 2'b10, d};
    endfunction

    // 16 random data bits from the seeded generator
    function automatic logic [15:0] rand_data();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic end_test();
        @(posedge clk_25m);
        test_seq <= test_seq + 1;
        @(posedge clk_25m);
    endtask

    initial
    begin
        repeat (16) @(posedge clk_25m);
        rst_n <= 1'b1;
        // clause 22 writes then reads
        for (int r = 1; r < 32; r += 6)
            send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd3, r[4:0], rand_data()), 1'b1);
        for (int r = 1; r < 32; r += 3)
            send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, r[4:0], 16'd0), 1'b1);
        end_test();
        // clause 45 address, write, read, read-increments, wrong mmd
        send_frame(c45(mdio_pkg::OP_C45_ADDR, mdio_pkg::MMD_DEVAD, 16'd4), 1'b1);
        send_frame(c45(mdio_pkg::OP_C45_WRITE, mdio_pkg::MMD_DEVAD, rand_data()), 1'b1);
        send_frame(c45(mdio_pkg::OP_C45_READ, mdio_pkg::MMD_DEVAD, 16'd0), 1'b1);
        repeat (3)
            send_frame(c45(mdio_pkg::OP_C45_READ_INC, mdio_pkg::MMD_DEVAD, 16'd0), 1'b1);
        send_frame(c45(mdio_pkg::OP_C45_READ, mdio_pkg::MMD_DEVAD, 16'd0), 1'b1);
        send_frame(c45(mdio_pkg::OP_C45_READ, 5'd2, 16'd0), 1'b1);
        end_test();
        // non-matching phy address
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd9, 5'd1, 16'd0), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd9, 5'd1, 16'hdead), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd1, 16'd0), 1'b1);
        end_test();
        // broadcast, then non-zero detect latch
        @(posedge clk_25m);
        cfg.broadcast_mode <= 1'b1;
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'h1f, 5'd7, rand_data()), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd7, 16'd0), 1'b1);
        @(posedge clk_25m);
        cfg <= '{5'd0, 5'h1f, 5'h1f, 1'b0, 1'b1, 1'b0, 1'b1};
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd5, 5'd13, rand_data()), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd5, 5'd13, 16'd0), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd6, 5'd13, rand_data()), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd5, 5'd13, 16'd0), 1'b1);
        @(posedge clk_25m);
        cfg <= '{5'd3, 5'h1f, 5'h1f, 1'b0, 1'b0, 1'b1, 1'b1};   // open-drain on
        end_test();
        // open-drain reads
        d0 = rand_data();
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd3, 5'd9, d0), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd3, 5'd12, 16'h0f0f), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd9, 16'd0), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd12, 16'd0), 1'b1);
        @(posedge clk_25m);
        cfg.opendrain_mode <= 1'b0;
        end_test();
        // back to back without preamble, then enable dropped mid-frame
        d1 = rand_data();
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd3, 5'd11, d1), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd11, 16'd0), 1'b0);
        send_frame(c22(mdio_pkg::OP_C22_WRITE, 5'd3, 5'd12, ~d1), 1'b0);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd12, 16'd0), 1'b0);
        repeat (32) drive_bit(1'b1);
        partial_word = c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd11, 16'd0);
        for (int i = 0; i < 20; i++)
            drive_bit(i < 14 ? partial_word[31 - i] : 1'b1);
        cfg.enable <= 1'b0;
        repeat (20) @(posedge clk_25m);
        cfg.enable <= 1'b1;
        repeat (4) drive_bit(1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd11, 16'd0), 1'b1);
        send_frame(c22(mdio_pkg::OP_C22_READ, 5'd3, 5'd12, 16'd0), 1'b1);
        send_frame(c45(mdio_pkg::OP_C45_READ, mdio_pkg::MMD_DEVAD, 16'd0), 1'b1);
        end_test();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // watchdog sized from the frame budget
    initial
    begin
        #(N_FRAMES * 64 * 16 * 40 + 200000);
        $display("timeout, the test sequence did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
